//--- common/result_buf_cfg.svh
`ifndef RESULT_BUF_CFG_SVH
`define RESULT_BUF_CFG_SVH

// ----------------------------------------
// batch geometry
// ----------------------------------------

// reads per batch
`define RB_MAX_READ 64
`define RB_READ_NUM_W 6

// batch size and done counter reach RB_MAX_READ itself
`define RB_COUNT_W (`RB_READ_NUM_W + 1)

// entry slots reserved for each read
`define RB_SLOTS_PER_READ 20

// sizes, indices and return codes share one width
`define RB_SIZE_W 7

// ----------------------------------------
// store banks
// ----------------------------------------

// bank picked by the two MSBs of the read number
`define RB_BANKS 4
`define RB_BANK_DEPTH (`RB_MAX_READ * `RB_SLOTS_PER_READ / `RB_BANKS)
`define RB_BANK_ADDR_W 9

// datapath slot and output beat widths
`define RB_SLOT_W 256
`define RB_BEAT_W 512

`endif

//--- common/result_buf_pkg.sv
`include "result_buf_cfg.svh"

package result_buf_pkg;

	// stored entry, only the live bits of a slot (113 bits)
	typedef struct packed {
		logic [6:0]  info_hi;
		logic [6:0]  info_lo;
		logic [32:0] x2;
		logic [32:0] x1;
		logic [32:0] x0;
	} mem_entry_t;

	// datapath form: [info_hi, info_lo, x2, x1, x0] on 32/64-bit lanes
	typedef logic [`RB_SLOT_W-1:0] mem_slot_t;

	typedef logic [`RB_BEAT_W-1:0] out_beat_t;

	// one sequencer step, finish marks the end of the batch
	typedef enum logic [2:0] {
		STEP_NONE,
		STEP_HEADER,
		STEP_PAIR,
		STEP_SINGLE,
		STEP_GAP,
		STEP_FINISH
	} step_kind_t;

	function automatic mem_entry_t pack_entry(input mem_slot_t slot);
		mem_entry_t e;
		e.info_hi = slot[224 +: 7];
		e.info_lo = slot[192 +: 7];
		e.x2      = slot[128 +: 33];
		e.x1      = slot[64 +: 33];
		e.x0      = slot[0 +: 33];
		return e;
	endfunction

	function automatic mem_slot_t unpack_entry(input mem_entry_t e);
		mem_slot_t slot;
		slot = '0;
		slot[224 +: 7]  = e.info_hi;
		slot[192 +: 7]  = e.info_lo;
		slot[128 +: 33] = e.x2;
		slot[64 +: 33]  = e.x1;
		slot[0 +: 33]   = e.x0;
		return slot;
	endfunction

endpackage

//--- mem_store/entry_bank_ram.sv
`include "result_buf_cfg.svh"

module entry_bank_ram (
	input  logic                        clk,
	input  logic                        en,
	input  logic                        we,
	input  logic [`RB_BANK_ADDR_W-1:0]  waddr,
	input  result_buf_pkg::mem_entry_t  wdata,
	input  logic [`RB_BANK_ADDR_W-1:0]  raddr_a,
	input  logic [`RB_BANK_ADDR_W-1:0]  raddr_b,
	output result_buf_pkg::mem_entry_t  q_a,
	output result_buf_pkg::mem_entry_t  q_b
);

	result_buf_pkg::mem_entry_t ram [`RB_BANK_DEPTH];

	// en is the inverted stall, so a stalled cycle neither writes nor moves q
	always_ff @(posedge clk) begin
		if (en) begin
			if (we) begin
				ram[waddr] <= wdata;
			end
			q_a <= ram[raddr_a];
			q_b <= ram[raddr_b];
		end
	end

endmodule

//--- mem_store/mem_store.sv
`include "result_buf_cfg.svh"

module mem_store (
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        stall,
	input  logic                        mem_we,
	input  logic [`RB_READ_NUM_W-1:0]   mem_read_num,
	input  logic [`RB_SIZE_W-1:0]       mem_addr,
	input  result_buf_pkg::mem_slot_t   mem_data,
	input  logic [`RB_READ_NUM_W-1:0]   rd_read_num,
	input  logic [`RB_SIZE_W-1:0]       rd_addr_a,
	input  logic [`RB_SIZE_W-1:0]       rd_addr_b,
	output result_buf_pkg::mem_entry_t  rd_entry_a,
	output result_buf_pkg::mem_entry_t  rd_entry_b
);

	localparam int ADDR_W = `RB_BANK_ADDR_W;
	localparam int SEL_W  = $clog2(`RB_BANKS);
	localparam int LOW_W  = `RB_READ_NUM_W - SEL_W;

	// row of a read inside its bank, plus the entry index
	function automatic logic [ADDR_W-1:0] bank_addr(
		input logic [`RB_READ_NUM_W-1:0] read_num,
		input logic [`RB_SIZE_W-1:0]     idx
	);
		logic [ADDR_W-1:0] base;
		base = ADDR_W'(read_num[LOW_W-1:0]) * ADDR_W'(`RB_SLOTS_PER_READ);
		return base + ADDR_W'(idx);
	endfunction

	// ----------------------------------------
	// write pipeline
	// ----------------------------------------
	logic                        we_q;
	logic [SEL_W-1:0]            wr_sel_q;
	logic [ADDR_W-1:0]           waddr_q, waddr_qq;
	result_buf_pkg::mem_entry_t  wdata_q, wdata_qq;
	logic [`RB_BANKS-1:0]        bank_we;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			we_q    <= 1'b0;
			bank_we <= '0;
		end else if (!stall) begin
			we_q     <= mem_we;
			wr_sel_q <= mem_read_num[`RB_READ_NUM_W-1 -: SEL_W];
			waddr_q  <= bank_addr(mem_read_num, mem_addr);
			wdata_q  <= result_buf_pkg::pack_entry(mem_data);
			// second stage turns the bank field into a one-hot enable
			bank_we  <= we_q ? (`RB_BANKS'(1) << wr_sel_q) : '0;
			waddr_qq <= waddr_q;
			wdata_qq <= wdata_q;
		end
	end

	// ----------------------------------------
	// read side
	// ----------------------------------------
	logic [ADDR_W-1:0]           raddr_a_q, raddr_b_q;
	logic [SEL_W-1:0]            rd_sel_q, rd_sel_qq;
	result_buf_pkg::mem_entry_t  bank_q_a [`RB_BANKS];
	result_buf_pkg::mem_entry_t  bank_q_b [`RB_BANKS];

	always_ff @(posedge clk) begin
		if (!stall) begin
			raddr_a_q  <= bank_addr(rd_read_num, rd_addr_a);
			raddr_b_q  <= bank_addr(rd_read_num, rd_addr_b);
			rd_sel_q   <= rd_read_num[`RB_READ_NUM_W-1 -: SEL_W];
			// wait out the RAM read, then pick the bank
			rd_sel_qq  <= rd_sel_q;
			rd_entry_a <= bank_q_a[rd_sel_qq];
			rd_entry_b <= bank_q_b[rd_sel_qq];
		end
	end

	for (genvar b = 0; b < `RB_BANKS; b++) begin : g_bank
		entry_bank_ram i_bank (
			.clk     (clk),
			.en      (!stall),
			.we      (bank_we[b]),
			.waddr   (waddr_qq),
			.wdata   (wdata_qq),
			.raddr_a (raddr_a_q),
			.raddr_b (raddr_b_q),
			.q_a     (bank_q_a[b]),
			.q_b     (bank_q_b[b])
		);
	end

endmodule

//--- verilog/group_table.sv
`include "result_buf_cfg.svh"

module group_table (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       stall,
	input  logic [`RB_COUNT_W-1:0]     batch_size,
	input  logic                       mem_size_valid,
	input  logic [`RB_SIZE_W-1:0]      mem_size,
	input  logic [`RB_READ_NUM_W-1:0]  mem_size_read_num,
	input  logic                       ret_valid,
	input  logic [`RB_SIZE_W-1:0]      ret,
	input  logic [`RB_READ_NUM_W-1:0]  ret_read_num,
	input  logic [`RB_READ_NUM_W-1:0]  lookup_read_num,
	output logic [`RB_SIZE_W-1:0]      lookup_size,
	output logic [`RB_SIZE_W-1:0]      lookup_ret,
	output logic [`RB_COUNT_W-1:0]     done_counter,
	output logic                       output_request
);

	logic [`RB_SIZE_W-1:0]      size_tab [`RB_MAX_READ];
	logic [`RB_SIZE_W-1:0]      ret_tab [`RB_MAX_READ];

	logic                       size_valid_q;
	logic [`RB_SIZE_W-1:0]      size_q;
	logic [`RB_READ_NUM_W-1:0]  size_read_num_q;
	logic                       ret_valid_q;
	logic [`RB_SIZE_W-1:0]      ret_q;
	logic [`RB_READ_NUM_W-1:0]  ret_read_num_q;
	logic                       all_done;

	// one register stage on the strobes
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			size_valid_q <= 1'b0;
			ret_valid_q  <= 1'b0;
		end else if (!stall) begin
			size_valid_q    <= mem_size_valid;
			size_q          <= mem_size;
			size_read_num_q <= mem_size_read_num;
			ret_valid_q     <= ret_valid;
			ret_q           <= ret;
			ret_read_num_q  <= ret_read_num;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			if (size_valid_q) begin
				size_tab[size_read_num_q] <= size_q;
			end
			if (ret_valid_q) begin
				ret_tab[ret_read_num_q] <= ret_q;
			end
		end
	end

	// completion count, then request one cycle behind all_done
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			done_counter   <= '0;
			all_done       <= 1'b0;
			output_request <= 1'b0;
		end else if (!stall) begin
			if (size_valid_q) begin
				done_counter <= done_counter + 1'b1;
			end
			all_done       <= (done_counter == batch_size) && (batch_size != '0);
			output_request <= all_done;
		end
	end

	assign lookup_size = size_tab[lookup_read_num];
	assign lookup_ret  = ret_tab[lookup_read_num];

endmodule

//--- output_stream/output_sequencer.sv
`include "result_buf_cfg.svh"

module output_sequencer (
	input  logic                              clk,
	input  logic                              reset_n,
	input  logic                              stall,
	input  logic                              output_permit,
	input  logic [`RB_COUNT_W-1:0]            batch_size,
	output logic [`RB_READ_NUM_W-1:0]         lookup_read_num,
	input  logic [`RB_SIZE_W-1:0]             lookup_size,
	input  logic [`RB_SIZE_W-1:0]             lookup_ret,
	output logic [`RB_READ_NUM_W-1:0]         rd_read_num,
	output logic [`RB_SIZE_W-1:0]             rd_addr_a,
	output logic [`RB_SIZE_W-1:0]             rd_addr_b,
	output result_buf_pkg::step_kind_t        step_kind,
	output logic [`RB_READ_NUM_W-1:0]         step_read_num,
	output logic [`RB_SIZE_W-1:0]             step_size,
	output logic [`RB_SIZE_W-1:0]             step_ret
);

	// matches address reg, RAM read and bank select in mem_store
	localparam int PIPE_DEPTH = 3;

	logic [`RB_COUNT_W-1:0]      read_ptr;
	logic [`RB_SIZE_W-1:0]       out_idx;
	logic [`RB_SIZE_W-1:0]       idx_next;
	logic [`RB_SIZE_W-1:0]       cur_size;
	logic                        group_start;
	result_buf_pkg::step_kind_t  step_now;

	result_buf_pkg::step_kind_t  kind_pipe [PIPE_DEPTH];
	logic [`RB_READ_NUM_W-1:0]   read_num_pipe [PIPE_DEPTH];
	logic [`RB_SIZE_W-1:0]       size_pipe [PIPE_DEPTH];
	logic [`RB_SIZE_W-1:0]       ret_pipe [PIPE_DEPTH];

	assign idx_next = out_idx + 1'b1;

	always_comb begin
		if (!output_permit)
			step_now = result_buf_pkg::STEP_NONE;
		else if (read_ptr >= batch_size)
			step_now = result_buf_pkg::STEP_FINISH;
		else if (group_start)
			step_now = result_buf_pkg::STEP_HEADER;
		else if (idx_next < cur_size)
			step_now = result_buf_pkg::STEP_PAIR;
		else if (idx_next == cur_size)
			step_now = result_buf_pkg::STEP_SINGLE;
		else
			step_now = result_buf_pkg::STEP_GAP;
	end

	// ----------------------------------------
	// walk reads and entries
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			read_ptr    <= '0;
			out_idx     <= '0;
			cur_size    <= '0;
			group_start <= 1'b1;
		end else if (!stall) begin
			case (step_now)
				result_buf_pkg::STEP_HEADER: begin
					cur_size    <= lookup_size;
					out_idx     <= '0;
					group_start <= 1'b0;
				end
				result_buf_pkg::STEP_PAIR:   out_idx <= out_idx + 2'd2;
				result_buf_pkg::STEP_SINGLE: out_idx <= idx_next;
				result_buf_pkg::STEP_GAP: begin
					read_ptr    <= read_ptr + 1'b1;
					group_start <= 1'b1;
				end
				default: ;
			endcase
		end
	end

	assign lookup_read_num = read_ptr[`RB_READ_NUM_W-1:0];
	assign rd_read_num     = read_ptr[`RB_READ_NUM_W-1:0];
	assign rd_addr_a       = out_idx;
	assign rd_addr_b       = idx_next;

	// step info rides alongside the store read
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < PIPE_DEPTH; i++) begin
				kind_pipe[i] <= result_buf_pkg::STEP_NONE;
			end
		end else if (!stall) begin
			kind_pipe[0]     <= step_now;
			read_num_pipe[0] <= read_ptr[`RB_READ_NUM_W-1:0];
			size_pipe[0]     <= lookup_size;
			ret_pipe[0]      <= lookup_ret;
			for (int i = 1; i < PIPE_DEPTH; i++) begin
				kind_pipe[i]     <= kind_pipe[i-1];
				read_num_pipe[i] <= read_num_pipe[i-1];
				size_pipe[i]     <= size_pipe[i-1];
				ret_pipe[i]      <= ret_pipe[i-1];
			end
		end
	end

	assign step_kind     = kind_pipe[PIPE_DEPTH-1];
	assign step_read_num = read_num_pipe[PIPE_DEPTH-1];
	assign step_size     = size_pipe[PIPE_DEPTH-1];
	assign step_ret      = ret_pipe[PIPE_DEPTH-1];

endmodule

//--- output_stream/beat_formatter.sv
`include "result_buf_cfg.svh"

module beat_formatter (
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        stall,
	input  result_buf_pkg::step_kind_t  step_kind,
	input  logic [`RB_READ_NUM_W-1:0]   step_read_num,
	input  logic [`RB_SIZE_W-1:0]       step_size,
	input  logic [`RB_SIZE_W-1:0]       step_ret,
	input  result_buf_pkg::mem_entry_t  rd_entry_a,
	input  result_buf_pkg::mem_entry_t  rd_entry_b,
	output result_buf_pkg::out_beat_t   output_data,
	output logic                        output_valid,
	output logic                        output_finish
);

	// header field offsets
	localparam int HDR_SIZE_LSB = 64;
	localparam int HDR_RET_LSB  = 128;

	result_buf_pkg::out_beat_t next_beat;
	logic                      next_valid;

	always_comb begin
		next_beat = '0;
		case (step_kind)
			result_buf_pkg::STEP_HEADER: begin
				next_beat[`RB_READ_NUM_W-1:0]            = step_read_num;
				next_beat[HDR_SIZE_LSB +: `RB_SIZE_W]    = step_size;
				next_beat[HDR_RET_LSB +: `RB_SIZE_W]     = step_ret;
			end
			result_buf_pkg::STEP_PAIR: begin
				next_beat = {result_buf_pkg::unpack_entry(rd_entry_b),
					result_buf_pkg::unpack_entry(rd_entry_a)};
			end
			// odd tail, upper half stays zero
			result_buf_pkg::STEP_SINGLE: begin
				next_beat[`RB_SLOT_W-1:0] = result_buf_pkg::unpack_entry(rd_entry_a);
			end
			default: ;
		endcase
	end

	assign next_valid = (step_kind == result_buf_pkg::STEP_HEADER) ||
		(step_kind == result_buf_pkg::STEP_PAIR) ||
		(step_kind == result_buf_pkg::STEP_SINGLE);

	always_ff @(posedge clk) begin
		if (!stall) begin
			output_data <= next_beat;
		end
	end

	// finish is sticky until reset
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			output_valid  <= 1'b0;
			output_finish <= 1'b0;
		end else if (!stall) begin
			output_valid <= next_valid;
			if (step_kind == result_buf_pkg::STEP_FINISH) begin
				output_finish <= 1'b1;
			end
		end
	end

endmodule

//--- verilog/result_buffer_top.sv
`include "result_buf_cfg.svh"

module result_buffer_top (
	input  logic                        clk,
	input  logic                        reset_n,
	input  logic                        stall,
	input  logic [`RB_COUNT_W-1:0]      batch_size,
	// entry writes from the datapath
	input  logic                        mem_we,
	input  logic [`RB_READ_NUM_W-1:0]   mem_read_num,
	input  logic [`RB_SIZE_W-1:0]       mem_addr,
	input  result_buf_pkg::mem_slot_t   mem_data,
	// per-read sideband
	input  logic                        mem_size_valid,
	input  logic [`RB_SIZE_W-1:0]       mem_size,
	input  logic [`RB_READ_NUM_W-1:0]   mem_size_read_num,
	input  logic                        ret_valid,
	input  logic [`RB_SIZE_W-1:0]       ret,
	input  logic [`RB_READ_NUM_W-1:0]   ret_read_num,
	output logic [`RB_COUNT_W-1:0]      done_counter,
	// output channel
	output logic                        output_request,
	input  logic                        output_permit,
	output result_buf_pkg::out_beat_t   output_data,
	output logic                        output_valid,
	output logic                        output_finish
);

	logic [`RB_READ_NUM_W-1:0]   lookup_read_num;
	logic [`RB_SIZE_W-1:0]       lookup_size;
	logic [`RB_SIZE_W-1:0]       lookup_ret;
	logic [`RB_READ_NUM_W-1:0]   rd_read_num;
	logic [`RB_SIZE_W-1:0]       rd_addr_a;
	logic [`RB_SIZE_W-1:0]       rd_addr_b;
	result_buf_pkg::mem_entry_t  rd_entry_a;
	result_buf_pkg::mem_entry_t  rd_entry_b;
	result_buf_pkg::step_kind_t  step_kind;
	logic [`RB_READ_NUM_W-1:0]   step_read_num;
	logic [`RB_SIZE_W-1:0]       step_size;
	logic [`RB_SIZE_W-1:0]       step_ret;

	mem_store i_mem_store (
		.clk          (clk),
		.reset_n      (reset_n),
		.stall        (stall),
		.mem_we       (mem_we),
		.mem_read_num (mem_read_num),
		.mem_addr     (mem_addr),
		.mem_data     (mem_data),
		.rd_read_num  (rd_read_num),
		.rd_addr_a    (rd_addr_a),
		.rd_addr_b    (rd_addr_b),
		.rd_entry_a   (rd_entry_a),
		.rd_entry_b   (rd_entry_b)
	);

	group_table i_group_table (
		.clk               (clk),
		.reset_n           (reset_n),
		.stall             (stall),
		.batch_size        (batch_size),
		.mem_size_valid    (mem_size_valid),
		.mem_size          (mem_size),
		.mem_size_read_num (mem_size_read_num),
		.ret_valid         (ret_valid),
		.ret               (ret),
		.ret_read_num      (ret_read_num),
		.lookup_read_num   (lookup_read_num),
		.lookup_size       (lookup_size),
		.lookup_ret        (lookup_ret),
		.done_counter      (done_counter),
		.output_request    (output_request)
	);

	output_sequencer i_output_sequencer (
		.clk             (clk),
		.reset_n         (reset_n),
		.stall           (stall),
		.output_permit   (output_permit),
		.batch_size      (batch_size),
		.lookup_read_num (lookup_read_num),
		.lookup_size     (lookup_size),
		.lookup_ret      (lookup_ret),
		.rd_read_num     (rd_read_num),
		.rd_addr_a       (rd_addr_a),
		.rd_addr_b       (rd_addr_b),
		.step_kind       (step_kind),
		.step_read_num   (step_read_num),
		.step_size       (step_size),
		.step_ret        (step_ret)
	);

	beat_formatter i_beat_formatter (
		.clk           (clk),
		.reset_n       (reset_n),
		.stall         (stall),
		.step_kind     (step_kind),
		.step_read_num (step_read_num),
		.step_size     (step_size),
		.step_ret      (step_ret),
		.rd_entry_a    (rd_entry_a),
		.rd_entry_b    (rd_entry_b),
		.output_data   (output_data),
		.output_valid  (output_valid),
		.output_finish (output_finish)
	);

endmodule

//--- verif/result_buffer_asserts.sv
module result_buffer_asserts (
	input logic                       clk,
	input logic                       reset_n,
	input logic                       stall,
	input result_buf_pkg::out_beat_t  output_data,
	input logic                       output_valid,
	input logic                       output_finish
);

	timeunit 1ns;
	timeprecision 100ps;

	int fail_count = 0;

	// finish closes the stream, no beat rides with it
	valid_not_with_finish: assert property (
		@(posedge clk) disable iff (!reset_n) !(output_valid && output_finish)
	) else begin
		fail_count++;
		$error("output_valid and output_finish high together");
	end

	no_valid_after_finish: assert property (
		@(posedge clk) disable iff (!reset_n) output_finish |=> !output_valid
	) else begin
		fail_count++;
		$error("output_valid rose after output_finish");
	end

	// a stalled edge leaves the beat register alone
	data_held_in_stall: assert property (
		@(posedge clk) disable iff (!reset_n) stall |=> $stable(output_data)
	) else begin
		fail_count++;
		$error("output_data changed across a stalled cycle");
	end

endmodule

bind result_buffer_top result_buffer_asserts i_asserts (.*);

//--- verif/result_buffer_checker.sv
`include "result_buf_cfg.svh"

module result_buffer_checker (
	input  logic                       clk,
	input  logic                       reset_n,
	input  logic                       stall,
	input  logic [`RB_COUNT_W-1:0]     batch_size,
	input  logic                       mem_we,
	input  logic [`RB_READ_NUM_W-1:0]  mem_read_num,
	input  logic [`RB_SIZE_W-1:0]      mem_addr,
	input  result_buf_pkg::mem_slot_t  mem_data,
	input  logic                       mem_size_valid,
	input  logic [`RB_SIZE_W-1:0]      mem_size,
	input  logic [`RB_READ_NUM_W-1:0]  mem_size_read_num,
	input  logic                       ret_valid,
	input  logic [`RB_SIZE_W-1:0]      ret,
	input  logic [`RB_READ_NUM_W-1:0]  ret_read_num,
	input  logic [`RB_COUNT_W-1:0]     done_counter,
	input  logic                       output_request,
	input  result_buf_pkg::out_beat_t  output_data,
	input  logic                       output_valid,
	input  logic                       output_finish,
	input  logic                       test_end,
	input  int                         test_num,
	output int                         error_count,
	output int                         tests_failed
);

	timeunit 1ns;
	timeprecision 100ps;

	// model of what the datapath handed over
	result_buf_pkg::mem_slot_t  model_slot [`RB_MAX_READ][`RB_SLOTS_PER_READ];
	int                         model_size [`RB_MAX_READ];
	logic [`RB_SIZE_W-1:0]      model_ret [`RB_MAX_READ];

	int  size_count;
	int  exp_read;
	int  exp_idx;
	int  beat_count;
	int  test_errors;
	bit  at_header;
	bit  finish_seen;
	bit  reset_q;

	initial begin
		error_count  = 0;
		tests_failed = 0;
		reset_q      = 1'b1;
	end

	task automatic value_error(input string name, input logic [511:0] got,
			input logic [511:0] exp);
		$display("** Error: %s got %0h, expected %0h", name, got, exp);
		error_count++;
	endtask

	task automatic plain_error(input string msg);
		$display("test %0d: %s", test_num, msg);
		error_count++;
	endtask

	// header carries read number, size at 64 and return code at 128
	function automatic result_buf_pkg::out_beat_t expected_beat(input int r, input int k,
			input bit hdr);
		result_buf_pkg::out_beat_t b;
		b = '0;
		if (hdr) begin
			b[`RB_READ_NUM_W-1:0] = `RB_READ_NUM_W'(r);
			b[64 +: `RB_SIZE_W]   = `RB_SIZE_W'(model_size[r]);
			b[128 +: `RB_SIZE_W]  = model_ret[r];
		end else begin
			b[255:0] = model_slot[r][k];
			if (k + 1 < model_size[r])
				b[511:256] = model_slot[r][k + 1];
		end
		return b;
	endfunction

	// ----------------------------------------
	// per-cycle monitor
	// ----------------------------------------
	always @(posedge clk) begin : monitor
		result_buf_pkg::out_beat_t exp_beat;
		int total;
		int r;
		if (!reset_n) begin
			size_count  = 0;
			exp_read    = 0;
			exp_idx     = 0;
			beat_count  = 0;
			at_header   = 1'b1;
			finish_seen = 1'b0;
			test_errors = error_count;
		end else begin
			// first edge out of reset
			if (!reset_q) begin
				if (output_request !== 1'b0)
					value_error("output_request", output_request, 0);
				if (output_valid !== 1'b0)
					value_error("output_valid", output_valid, 0);
				if (output_finish !== 1'b0)
					value_error("output_finish", output_finish, 0);
				if (done_counter !== '0)
					value_error("done_counter", done_counter, 0);
			end
			if (!stall) begin
				if (mem_we)
					model_slot[mem_read_num][mem_addr] = mem_data;
				if (mem_size_valid) begin
					model_size[mem_size_read_num] = mem_size;
					size_count++;
				end
				if (ret_valid)
					model_ret[ret_read_num] = ret;
			end
			if (output_request && size_count < batch_size)
				value_error("output_request", output_request, 0);
			// a beat is taken on an un-stalled edge
			if (output_valid && !stall) begin
				if (finish_seen || output_finish) begin
					plain_error("valid beat seen after output_finish");
				end else if (exp_read >= batch_size) begin
					plain_error("valid beat beyond the last read");
				end else begin
					exp_beat = expected_beat(exp_read, exp_idx, at_header);
					if (output_data !== exp_beat)
						value_error($sformatf("output_data of read %0d", exp_read),
							output_data, exp_beat);
					if (at_header) begin
						at_header = 1'b0;
						exp_idx   = 0;
					end else begin
						exp_idx += 2;
					end
					if (!at_header && exp_idx >= model_size[exp_read]) begin
						at_header = 1'b1;
						exp_read++;
					end
				end
				beat_count++;
			end
			if (output_finish)
				finish_seen = 1'b1;
			if (test_end) begin
				total = 0;
				for (r = 0; r < batch_size; r++)
					total += 1 + (model_size[r] + 1) / 2;
				if (done_counter !== size_count)
					value_error("done_counter", done_counter, size_count);
				// finish stays up until the next reset
				if (output_finish !== 1'b1)
					value_error("output_finish", output_finish, 1);
				if (beat_count != total)
					plain_error($sformatf("%0d valid beats, %0d expected", beat_count, total));
				if (error_count == test_errors) begin
					$display("test %0d: %0d reads, %0d beats, ok", test_num, batch_size,
						beat_count);
				end else begin
					tests_failed++;
					$display("test %0d: %0d reads, %0d beats, FAILED with %0d errors",
						test_num, batch_size, beat_count, error_count - test_errors);
				end
			end
		end
		reset_q = reset_n;
	end

endmodule

//--- verif/result_buffer_tb.sv
`include "result_buf_cfg.svh"

module result_buffer_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int NUM_TESTS      = 5;
	localparam int REQ_TIMEOUT    = 500;
	localparam int FINISH_TIMEOUT = 20000;

	logic                        clk;
	logic                        reset_n;
	logic                        stall;
	logic [`RB_COUNT_W-1:0]      batch_size;
	logic                        mem_we;
	logic [`RB_READ_NUM_W-1:0]   mem_read_num;
	logic [`RB_SIZE_W-1:0]       mem_addr;
	result_buf_pkg::mem_slot_t   mem_data;
	logic                        mem_size_valid;
	logic [`RB_SIZE_W-1:0]       mem_size;
	logic [`RB_READ_NUM_W-1:0]   mem_size_read_num;
	logic                        ret_valid;
	logic [`RB_SIZE_W-1:0]       ret;
	logic [`RB_READ_NUM_W-1:0]   ret_read_num;
	logic [`RB_COUNT_W-1:0]      done_counter;
	logic                        output_request;
	logic                        output_permit;
	result_buf_pkg::out_beat_t   output_data;
	logic                        output_valid;
	logic                        output_finish;

	logic         test_end;
	int           test_num;
	int           error_count;
	int           tests_failed;
	logic [31:0]  rng_state;
	int           read_size [`RB_MAX_READ];
	int           size_order [`RB_MAX_READ];
	int           ret_order [`RB_MAX_READ];

	result_buffer_top i_dut (.*);

	result_buffer_checker i_checker (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------
	// random numbers
	// ----------------------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// only the five field ranges carry data
	function automatic result_buf_pkg::mem_slot_t random_slot();
		result_buf_pkg::mem_slot_t s;
		logic [31:0] a;
		s = '0;
		a = next_random();
		s[224 +: 7]  = a[6:0];
		s[192 +: 7]  = a[13:7];
		s[128 +: 33] = {a[14], next_random()};
		s[64 +: 33]  = {a[15], next_random()};
		s[0 +: 33]   = {a[16], next_random()};
		return s;
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	task automatic clear_inputs();
		stall             = 1'b0;
		mem_we            = 1'b0;
		mem_read_num      = '0;
		mem_addr          = '0;
		mem_data          = '0;
		mem_size_valid    = 1'b0;
		mem_size          = '0;
		mem_size_read_num = '0;
		ret_valid         = 1'b0;
		ret               = '0;
		ret_read_num      = '0;
	endtask

	task automatic apply_reset();
		reset_n = 1'b0;
		repeat (3) next_cycle();
		reset_n = 1'b1;
	endtask

	task automatic shuffle_reads(input int n, output int perm [`RB_MAX_READ]);
		int j;
		int tmp;
		for (int i = 0; i < `RB_MAX_READ; i++)
			perm[i] = i;
		for (int i = n - 1; i > 0; i--) begin
			j       = next_random() % (i + 1);
			tmp     = perm[i];
			perm[i] = perm[j];
			perm[j] = tmp;
		end
	endtask

	// ----------------------------------------
	// collection phase
	// ----------------------------------------
	task automatic write_entries(input int n);
		for (int r = 0; r < n; r++) begin
			for (int k = 0; k < read_size[r]; k++) begin
				mem_we       = 1'b1;
				mem_read_num = `RB_READ_NUM_W'(r);
				mem_addr     = `RB_SIZE_W'(k);
				mem_data     = random_slot();
				next_cycle();
			end
		end
		mem_we = 1'b0;
	endtask

	task automatic send_sideband(input int n);
		logic [31:0] a;
		shuffle_reads(n, size_order);
		shuffle_reads(n, ret_order);
		for (int i = 0; i < n; i++) begin
			a = next_random();
			mem_size_valid    = 1'b1;
			mem_size_read_num = `RB_READ_NUM_W'(size_order[i]);
			mem_size          = `RB_SIZE_W'(read_size[size_order[i]]);
			ret_valid         = 1'b1;
			ret_read_num      = `RB_READ_NUM_W'(ret_order[i]);
			ret               = a[6:0];
			next_cycle();
			mem_size_valid = 1'b0;
			ret_valid      = 1'b0;
			// an idle gap now and then
			if (a[8:7] == 2'b00)
				next_cycle();
		end
	endtask

	task automatic wait_request(output bit ok);
		int cycles;
		cycles = 0;
		while (!output_request && cycles < REQ_TIMEOUT) begin
			next_cycle();
			cycles++;
		end
		ok = output_request;
	endtask

	// permit toggles and stall pulses while the batch drains
	task automatic stream_batch(output bit ok);
		int cycles;
		logic [31:0] a;
		cycles = 0;
		while (!output_finish && cycles < FINISH_TIMEOUT) begin
			a = next_random();
			output_permit = (a[1:0] != 2'b00);
			stall         = (a[4:2] == 3'b000);
			next_cycle();
			cycles++;
		end
		output_permit = 1'b1;
		stall         = 1'b0;
		ok = output_finish;
	endtask

	task automatic run_test(input int t, input int n, output bit ok);
		test_num      = t;
		batch_size    = `RB_COUNT_W'(n);
		output_permit = 1'b0;
		apply_reset();
		for (int r = 0; r < n; r++)
			read_size[r] = next_random() % (`RB_SLOTS_PER_READ + 1);
		// zero, odd and full groups in every larger batch
		if (n > 3) begin
			read_size[1] = 0;
			read_size[2] = `RB_SLOTS_PER_READ - 1;
			read_size[3] = `RB_SLOTS_PER_READ;
		end
		write_entries(n);
		send_sideband(n);
		wait_request(ok);
		if (!ok) begin
			$display("test %0d: output_request did not rise in time", t);
			return;
		end
		stream_batch(ok);
		if (!ok) begin
			$display("test %0d: output_finish did not rise in time", t);
			return;
		end
		// quiet tail, nothing valid may follow finish
		repeat (8) next_cycle();
		test_end = 1'b1;
		next_cycle();
		test_end = 1'b0;
	endtask

	initial begin
		int n;
		bit ok;
		bit timed_out;
		int tests_run;
		rng_state     = 32'h9a73_8c43;
		timed_out     = 1'b0;
		tests_run     = 0;
		test_end      = 1'b0;
		test_num      = 0;
		reset_n       = 1'b0;
		batch_size    = '0;
		output_permit = 1'b0;
		clear_inputs();
		for (int t = 0; t < NUM_TESTS && !timed_out; t++) begin
			// first batch fills all four banks
			n = (t == 0) ? `RB_MAX_READ : 1 + next_random() % `RB_MAX_READ;
			run_test(t, n, ok);
			timed_out = !ok;
			tests_run++;
		end
		$display("tests run %0d, failed %0d, timeouts %0d, errors %0d, assertion failures %0d",
			tests_run, tests_failed, timed_out, error_count, i_dut.i_asserts.fail_count);
		if (!timed_out && error_count == 0 && tests_failed == 0 &&
				i_dut.i_asserts.fail_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

//--- verilog.f
+incdir+common
common/result_buf_pkg.sv
mem_store/entry_bank_ram.sv
mem_store/mem_store.sv
verilog/group_table.sv
output_stream/output_sequencer.sv
output_stream/beat_formatter.sv
verilog/result_buffer_top.sv
verif/result_buffer_asserts.sv
verif/result_buffer_checker.sv
verif/result_buffer_tb.sv

//--- Bender.yml
package:
  name: result_buffer

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/result_buf_pkg.sv
      - mem_store/entry_bank_ram.sv
      - mem_store/mem_store.sv
      - verilog/group_table.sv
      - output_stream/output_sequencer.sv
      - output_stream/beat_formatter.sv
      - verilog/result_buffer_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/result_buffer_asserts.sv
      - verif/result_buffer_checker.sv
      - verif/result_buffer_tb.sv
